// ==== Bender.yml ====
package:
  name: frame_detector

sources:
  # Design sources in compile order
  - files:
      - hw/frame_detector_pkg.sv
      - hw/frame_stream_if.sv
      - hw/pattern_store.sv
      - hw/frame_offset_counter.sv
      - hw/frame_matcher.sv
      - hw/sync_fifo.sv
      - hw/frame_detector.sv
  # Simulation only
  - target: test
    files:
      - testbench/tb_frame_detector.sv

// ==== hw/frame_detector.sv ====
// Frame detector top level, loop FIFO plus pattern matching into an event queue
`default_nettype none

module frame_detector #(
	parameter int LOOP_DEPTH = 64,
	parameter int EVT_DEPTH = 8
) (
	input logic clk,
	input logic rst,

	// Configuration strobe
	input logic cfg_we,
	input logic [frame_detector_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input logic [frame_detector_pkg::CFG_DATA_W-1:0] cfg_wdata,

	// Receive stream, no back-pressure
	input logic [7:0] s_tdata,
	input logic s_tuser,
	input logic s_tlast,
	input logic s_tvalid,

	// Transmit stream
	output logic [7:0] m_tdata,
	output logic m_tuser,
	output logic m_tlast,
	output logic m_tvalid,
	input logic m_tready,

	input logic [frame_detector_pkg::TIME_W-1:0] current_time,

	// Event queue
	input logic evt_pop,
	output logic evt_valid,
	output logic [frame_detector_pkg::TIME_W-1:0] evt_time,
	output logic [frame_detector_pkg::N_PATTERNS-1:0] evt_matched,
	output logic evt_overflow
);
	import frame_detector_pkg::*;

	frame_stream_if rx ();

	frame_byte_t loop_din;
	frame_byte_t loop_dout;
	logic loop_pop;

	logic [OFFSET_W-1:0] offset;
	logic past_pattern;
	logic global_en;
	logic [N_PATTERNS-1:0] pattern_en;
	pattern_byte_t [N_PATTERNS-1:0] pattern_bytes;

	logic evt_push;
	logic evt_full;
	match_event_t evt_data;
	match_event_t evt_dout;

	// Receive port onto the internal stream
	assign rx.tdata = s_tdata;
	assign rx.tuser = s_tuser;
	assign rx.tlast = s_tlast;
	assign rx.tvalid = s_tvalid;

	// Loop path, bytes pass through untouched
	assign loop_din = '{tdata: rx.tdata, tuser: rx.tuser, tlast: rx.tlast};
	assign loop_pop = m_tvalid && m_tready;

	sync_fifo #(.payload_t(frame_byte_t), .DEPTH(LOOP_DEPTH)) loop_fifo (
		.clk(clk),
		.rst(rst),
		.push(rx.tvalid),
		.din(loop_din),
		.pop(loop_pop),
		.dout(loop_dout),
		.not_empty(m_tvalid),
		// Overflow caught by the FIFO assertion
		.full()
	);

	assign m_tdata = loop_dout.tdata;
	assign m_tuser = loop_dout.tuser;
	assign m_tlast = loop_dout.tlast;

	// Detection path
	frame_offset_counter offset_counter (
		.clk(clk),
		.rst(rst),
		.beat(rx.tvalid),
		.last(rx.tlast),
		.offset(offset),
		.past_pattern(past_pattern)
	);

	pattern_store store (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.offset(offset),
		.global_en(global_en),
		.pattern_en(pattern_en),
		.pattern_bytes(pattern_bytes)
	);

	frame_matcher matcher (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.offset(offset),
		.past_pattern(past_pattern),
		.global_en(global_en),
		.pattern_en(pattern_en),
		.pattern_bytes(pattern_bytes),
		.current_time(current_time),
		.evt_push(evt_push),
		.evt_data(evt_data)
	);

	// Event queue, new events dropped when full
	sync_fifo #(.payload_t(match_event_t), .DEPTH(EVT_DEPTH)) evt_fifo (
		.clk(clk),
		.rst(rst),
		.push(evt_push && !evt_full),
		.din(evt_data),
		.pop(evt_pop),
		.dout(evt_dout),
		.not_empty(evt_valid),
		.full(evt_full)
	);

	assign evt_time = evt_dout.timestamp;
	assign evt_matched = evt_dout.matched;

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (rst) begin
			evt_overflow <= 1'b0;
		end else if (evt_push && evt_full) begin
			evt_overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_detector_pkg.sv ====
// Frame detector package with pattern geometry, configuration map and payload types
`default_nettype none

package frame_detector_pkg;

	// Pattern geometry
	localparam int N_PATTERNS = 3;
	localparam int PATTERN_LEN = 16;
	localparam int BYTE_IDX_W = $clog2(PATTERN_LEN);
	// One spare bit so the offset can rest at PATTERN_LEN
	localparam int OFFSET_W = 5;

	// Free-running time base
	localparam int TIME_W = 64;

	// Configuration port
	localparam int CFG_ADDR_W = 7;
	localparam int CFG_DATA_W = 16;

	// Control register at address 0
	localparam logic [CFG_ADDR_W-1:0] CFG_CTRL_ADDR = 7'h00;
	localparam int CTRL_GLOBAL_EN_BIT = 0;
	localparam int CTRL_PATTERN_EN_LSB = 1;

	// Pattern byte writes, bit 6 set, index in 5:4, byte offset in 3:0
	localparam int CFG_PAT_SEL_BIT = 6;
	localparam int CFG_PAT_IDX_LSB = 4;
	localparam int CFG_PAT_IDX_W = 2;

	// High byte of write data is the mask, low byte the value
	typedef struct packed {
		logic [7:0] mask;
		logic [7:0] value;
	} pattern_byte_t;

	// Queued detection
	typedef struct packed {
		logic [TIME_W-1:0] timestamp;
		logic [N_PATTERNS-1:0] matched;
	} match_event_t;

	// One stream beat as stored in the loop FIFO
	typedef struct packed {
		logic [7:0] tdata;
		logic tuser;
		logic tlast;
	} frame_byte_t;

endpackage

`default_nettype wire

// ==== hw/frame_matcher.sv ====
// Frame matcher FSM tracking per-pattern mismatches and raising an event at frame end
`default_nettype none

module frame_matcher (
	input logic clk,
	input logic rst,

	// Receive stream, observed only
	frame_stream_if.sink rx,

	// Position from the offset counter
	input logic [frame_detector_pkg::OFFSET_W-1:0] offset,
	input logic past_pattern,

	// Configuration from the pattern store
	input logic global_en,
	input logic [frame_detector_pkg::N_PATTERNS-1:0] pattern_en,
	input frame_detector_pkg::pattern_byte_t [frame_detector_pkg::N_PATTERNS-1:0] pattern_bytes,

	input logic [frame_detector_pkg::TIME_W-1:0] current_time,

	// Event towards the event FIFO
	output logic evt_push,
	output frame_detector_pkg::match_event_t evt_data
);
	import frame_detector_pkg::*;

	typedef enum logic [1:0] {IDLE, IN_FRAME, DISCARD} state_t;

	state_t state;

	logic [N_PATTERNS-1:0] still_matching;
	logic [N_PATTERNS-1:0] byte_hit;
	logic [N_PATTERNS-1:0] match_now;
	logic [N_PATTERNS-1:0] hit_mask;
	logic long_enough;
	logic push_now;

	// Masked compare of the current byte, anything past the pattern is a hit
	always_comb begin
		for (int p = 0; p < N_PATTERNS; p++) begin
			byte_hit[p] = past_pattern ||
				(((rx.tdata ^ pattern_bytes[p].value) & pattern_bytes[p].mask) == 8'h00);
		end
	end

	// First byte of a frame starts with every pattern alive
	assign match_now = ((state == IN_FRAME) ? still_matching : {N_PATTERNS{1'b1}}) & byte_hit;
	assign hit_mask = match_now & pattern_en;

	// Last byte counts toward the length
	assign long_enough = past_pattern || (offset == OFFSET_W'(PATTERN_LEN - 1));

	// Good frame ending now with at least one enabled hit
	assign push_now = rx.tvalid && rx.tlast && !rx.tuser && (state != DISCARD) &&
		long_enough && global_en && (hit_mask != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			still_matching <= '0;
			evt_push <= 1'b0;
		end else begin
			evt_push <= push_now;
			if (rx.tvalid) begin
				case (state)
					IDLE, IN_FRAME: begin
						still_matching <= match_now;
						if (rx.tlast) begin
							state <= IDLE;
						end else if (rx.tuser) begin
							// Bad frame, ignore the rest
							state <= DISCARD;
						end else begin
							state <= IN_FRAME;
						end
					end
					DISCARD: begin
						if (rx.tlast) begin
							state <= IDLE;
						end
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// Timestamp taken in the tlast cycle
	always_ff @(posedge clk) begin
		if (push_now) begin
			evt_data.timestamp <= current_time;
			evt_data.matched <= hit_mask;
		end
	end

	// One event per frame, and frames are at least one byte apart
	assert property (@(posedge clk) disable iff (rst) evt_push |=> !evt_push)
		else $error("frame_matcher: event strobe on consecutive cycles");

endmodule

`default_nettype wire

// ==== hw/frame_offset_counter.sv ====
// Byte offset counter within a frame, saturating at the pattern length
`default_nettype none

module frame_offset_counter (
	input logic clk,
	input logic rst,

	// Accepted byte and its end marker
	input logic beat,
	input logic last,

	output logic [frame_detector_pkg::OFFSET_W-1:0] offset,
	output logic past_pattern
);
	import frame_detector_pkg::*;

	localparam logic [OFFSET_W-1:0] OFFSET_MAX = OFFSET_W'(PATTERN_LEN);

	always_ff @(posedge clk) begin
		if (rst) begin
			offset <= '0;
		end else if (beat) begin
			if (last) begin
				// Next beat starts a new frame
				offset <= '0;
			end else if (offset != OFFSET_MAX) begin
				offset <= offset + 1'b1;
			end
		end
	end

	// All pattern bytes already seen
	assign past_pattern = (offset == OFFSET_MAX);

endmodule

`default_nettype wire

// ==== hw/frame_stream_if.sv ====
// Byte stream interface between the receive port and its consumers
`default_nettype none

interface frame_stream_if;

	// Byte payload
	logic [7:0] tdata;
	// Bad frame marker, any beat
	logic tuser;
	// Final byte of the frame
	logic tlast;
	// No ready, every valid beat is taken
	logic tvalid;

	// Driven by the receive side
	modport source (
		output tdata,
		output tuser,
		output tlast,
		output tvalid
	);

	// Observers of the stream
	modport sink (
		input tdata,
		input tuser,
		input tlast,
		input tvalid
	);

endinterface

`default_nettype wire

// ==== hw/pattern_store.sv ====
// Pattern store holding enables and per-byte value/mask, read at the current offset
`default_nettype none

module pattern_store (
	input logic clk,
	input logic rst,

	// Configuration strobe
	input logic cfg_we,
	input logic [frame_detector_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input logic [frame_detector_pkg::CFG_DATA_W-1:0] cfg_wdata,

	// Byte position in the current frame
	input logic [frame_detector_pkg::OFFSET_W-1:0] offset,

	output logic global_en,
	output logic [frame_detector_pkg::N_PATTERNS-1:0] pattern_en,
	output frame_detector_pkg::pattern_byte_t [frame_detector_pkg::N_PATTERNS-1:0] pattern_bytes
);
	import frame_detector_pkg::*;

	pattern_byte_t patterns [N_PATTERNS][PATTERN_LEN];

	logic ctrl_wr;
	logic pat_wr;
	logic [CFG_PAT_IDX_W-1:0] pat_idx;
	logic [BYTE_IDX_W-1:0] pat_ofs;

	// Address decode
	assign pat_idx = cfg_addr[CFG_PAT_IDX_LSB +: CFG_PAT_IDX_W];
	assign pat_ofs = cfg_addr[BYTE_IDX_W-1:0];
	assign ctrl_wr = cfg_we && (cfg_addr == CFG_CTRL_ADDR);
	// Index 3 has no pattern behind it
	assign pat_wr = cfg_we && cfg_addr[CFG_PAT_SEL_BIT] && (pat_idx < N_PATTERNS);

	always_ff @(posedge clk) begin
		if (rst) begin
			global_en <= 1'b0;
			pattern_en <= '0;
			// All bytes come up as don't care
			for (int p = 0; p < N_PATTERNS; p++) begin
				for (int b = 0; b < PATTERN_LEN; b++) begin
					patterns[p][b] <= '0;
				end
			end
		end else begin
			if (ctrl_wr) begin
				global_en <= cfg_wdata[CTRL_GLOBAL_EN_BIT];
				pattern_en <= cfg_wdata[CTRL_PATTERN_EN_LSB +: N_PATTERNS];
			end
			if (pat_wr) begin
				patterns[pat_idx][pat_ofs] <= pattern_byte_t'(cfg_wdata);
			end
		end
	end

	// Column read, one byte of every pattern
	always_comb begin
		for (int p = 0; p < N_PATTERNS; p++) begin
			if (offset < PATTERN_LEN) begin
				pattern_bytes[p] = patterns[p][offset[BYTE_IDX_W-1:0]];
			end else begin
				// Beyond the pattern, zero mask matches anything
				pattern_bytes[p] = '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sync_fifo.sv ====
// Show-ahead synchronous FIFO on a register array, payload set by type parameter
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst,

	// Write side
	input logic push,
	input payload_t din,

	// Read side, head always visible on dout
	input logic pop,
	output payload_t dout,

	output logic not_empty,
	output logic full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// Pop on empty ignored
	assign do_pop = pop && not_empty;
	// A pop frees the slot for a same-cycle push
	assign do_push = push && (!full || do_pop);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	assign dout = mem[rd_ptr];
	assign not_empty = (count != '0);
	assign full = (count == CNT_W'(DEPTH));

	// Writer must respect full unless a pop makes room
	assert property (@(posedge clk) disable iff (rst) !(push && full && !pop))
		else $error("sync_fifo: push while full");

endmodule

`default_nettype wire

// ==== project.f ====
hw/frame_detector_pkg.sv
hw/frame_stream_if.sv
hw/pattern_store.sv
hw/frame_offset_counter.sv
hw/frame_matcher.sv
hw/sync_fifo.sv
hw/frame_detector.sv
testbench/tb_frame_detector.sv

// ==== testbench/tb_frame_detector.sv ====
// Testbench for the frame detector driving table frames with loopback and event queue checks
`default_nettype none

module tb_frame_detector;
	import frame_detector_pkg::*;

	localparam int LOOP_DEPTH = 64;
	localparam int EVT_DEPTH = 4;
	localparam int MAX_TESTS = 16;
	localparam int MAX_LEN = 24;
	localparam int PAT_BITS = 8 * PATTERN_LEN;

	logic clk = 1'b0;
	logic rst;
	logic cfg_we;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [CFG_DATA_W-1:0] cfg_wdata;
	logic [7:0] s_tdata;
	logic s_tuser;
	logic s_tlast;
	logic s_tvalid;
	logic [7:0] m_tdata;
	logic m_tuser;
	logic m_tlast;
	logic m_tvalid;
	logic m_tready;
	logic evt_pop;
	logic evt_valid;
	logic [TIME_W-1:0] evt_time;
	logic [N_PATTERNS-1:0] evt_matched;
	logic evt_overflow;
	// Free-running time base with the upper word set to catch truncation
	logic [TIME_W-1:0] current_time = 64'h0000_0001_0000_0000;

	// Test table with one row per frame
	string t_name [MAX_TESTS];
	logic [N_PATTERNS-1:0][PAT_BITS-1:0] t_pval [MAX_TESTS];
	logic [N_PATTERNS-1:0][PAT_BITS-1:0] t_pmask [MAX_TESTS];
	logic [CFG_DATA_W-1:0] t_ctrl [MAX_TESTS];
	logic [8*MAX_LEN-1:0] t_frame [MAX_TESTS];
	int t_len [MAX_TESTS];
	logic t_bad [MAX_TESTS];
	logic [N_PATTERNS-1:0] t_exp [MAX_TESTS];
	logic t_pop [MAX_TESTS];
	int n_tests = 0;

	// Scoreboard state
	logic [9:0] exp_bytes [$];
	logic [TIME_W-1:0] exp_time_q [$];
	logic [N_PATTERNS-1:0] exp_mask_q [$];
	logic exp_overflow = 1'b0;
	string cur_name = "reset";
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int watchdog_cycles = 0;
	integer seed = 32642;
	integer ready_rnd;

	frame_detector #(
		.LOOP_DEPTH(LOOP_DEPTH),
		.EVT_DEPTH(EVT_DEPTH)
	) uut (
		.clk(clk),
		.rst(rst),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.s_tdata(s_tdata),
		.s_tuser(s_tuser),
		.s_tlast(s_tlast),
		.s_tvalid(s_tvalid),
		.m_tdata(m_tdata),
		.m_tuser(m_tuser),
		.m_tlast(m_tlast),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready),
		.current_time(current_time),
		.evt_pop(evt_pop),
		.evt_valid(evt_valid),
		.evt_time(evt_time),
		.evt_matched(evt_matched),
		.evt_overflow(evt_overflow)
	);

	initial begin
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		current_time <= current_time + 1'b1;
	end

	// Random back-pressure on the transmit side
	always @(negedge clk) begin
		ready_rnd = $random(seed);
		m_tready = ready_rnd[0];
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			error_count++;
		end
	endtask

	// Loopback order and content checked on every handshake
	always @(posedge clk) begin
		if (!rst && m_tvalid && m_tready) begin
			if (exp_bytes.size() == 0) begin
				$display("Unexpected byte on the transmit port during %s", cur_name);
				error_count++;
			end else begin
				check_value({cur_name, " loopback"}, exp_bytes.pop_front(),
					{m_tdata, m_tuser, m_tlast});
			end
		end
	end

	// Deterministic frame content
	function automatic logic [8*MAX_LEN-1:0] make_frame(input logic [7:0] base);
		logic [8*MAX_LEN-1:0] f;
		logic [7:0] b;
		b = base;
		for (int k = 0; k < MAX_LEN; k++) begin
			f[8*k +: 8] = b;
			b = b + 8'd29;
		end
		return f;
	endfunction

	// Matching rule on the whole frame
	function automatic logic [N_PATTERNS-1:0] rule_mask(input int i);
		logic [N_PATTERNS-1:0] hits;
		logic [7:0] diff;
		hits = '0;
		if (t_bad[i] || (t_len[i] < PATTERN_LEN) || !t_ctrl[i][0]) begin
			return '0;
		end
		for (int p = 0; p < N_PATTERNS; p++) begin
			hits[p] = t_ctrl[i][1 + p];
			for (int k = 0; k < PATTERN_LEN; k++) begin
				diff = (t_frame[i][8*k +: 8] ^ t_pval[i][p][8*k +: 8]) & t_pmask[i][p][8*k +: 8];
				if (diff != 8'h00) begin
					hits[p] = 1'b0;
				end
			end
		end
		return hits;
	endfunction

	task automatic add_test(input string name, input logic [N_PATTERNS-1:0][PAT_BITS-1:0] pval,
		input logic [N_PATTERNS-1:0][PAT_BITS-1:0] pmask, input logic [CFG_DATA_W-1:0] ctrl,
		input logic [8*MAX_LEN-1:0] frame, input int len, input logic bad,
		input logic [N_PATTERNS-1:0] expected, input logic pop_now);
		t_name[n_tests] = name;
		t_pval[n_tests] = pval;
		t_pmask[n_tests] = pmask;
		t_ctrl[n_tests] = ctrl;
		t_frame[n_tests] = frame;
		t_len[n_tests] = len;
		t_bad[n_tests] = bad;
		t_exp[n_tests] = expected;
		t_pop[n_tests] = pop_now;
		n_tests++;
	endtask

	task automatic build_table();
		logic [8*MAX_LEN-1:0] frame_a;
		logic [PAT_BITS-1:0] byte3;
		logic [N_PATTERNS-1:0][PAT_BITS-1:0] pval;
		logic [N_PATTERNS-1:0][PAT_BITS-1:0] exact_mask;
		logic [N_PATTERNS-1:0][PAT_BITS-1:0] dc_mask;
		frame_a = make_frame(8'h5d);
		byte3 = '0;
		byte3[31:24] = 8'hff;
		// P0 is an exact copy and P1 differs at byte 3
		pval[0] = frame_a[PAT_BITS-1:0];
		pval[1] = frame_a[PAT_BITS-1:0] ^ byte3;
		// P2 only checks the high nibble of byte 0
		pval[2] = {{(PATTERN_LEN-1){8'haa}}, frame_a[7:4], 4'h3};
		exact_mask[0] = '1;
		exact_mask[1] = '1;
		exact_mask[2] = {{(PATTERN_LEN-1){8'h00}}, 8'hf0};
		// Byte 3 of P1 becomes don't care
		dc_mask = exact_mask;
		dc_mask[1] = ~byte3;
		add_test("exact_p0", pval, exact_mask, 16'h7, frame_a, 20, 1'b0, 3'b001, 1'b1);
		add_test("dont_care_multi", pval, dc_mask, 16'hf, frame_a, 20, 1'b0, 3'b111, 1'b1);
		add_test("no_pattern_enabled", pval, dc_mask, 16'h1, frame_a, 20, 1'b0, 3'b000, 1'b1);
		add_test("mismatch_only", pval, exact_mask, 16'h5, frame_a, 20, 1'b0, 3'b000, 1'b1);
		add_test("global_off", pval, dc_mask, 16'he, frame_a, 20, 1'b0, 3'b000, 1'b1);
		add_test("bad_frame", pval, dc_mask, 16'hf, frame_a, 20, 1'b1, 3'b000, 1'b1);
		add_test("short_15", pval, dc_mask, 16'hf, frame_a, 15, 1'b0, 3'b000, 1'b1);
		add_test("len_16", pval, dc_mask, 16'hf, frame_a, 16, 1'b0, 3'b111, 1'b1);
		// Events pile up unpopped until the last one overflows and drains the queue
		for (int q = 0; q <= EVT_DEPTH; q++) begin
			add_test($sformatf("queue_%0d", q), pval, dc_mask, (q % 2) ? 16'h9 : 16'h3,
				frame_a, 18, 1'b0, (q % 2) ? 3'b100 : 3'b001, q == EVT_DEPTH);
		end
	endtask

	task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
	endtask

	task automatic load_config(input int i);
		logic [CFG_ADDR_W-1:0] addr;
		for (int p = 0; p < N_PATTERNS; p++) begin
			for (int k = 0; k < PATTERN_LEN; k++) begin
				addr = {1'b1, p[1:0], k[3:0]};
				cfg_write(addr, {t_pmask[i][p][8*k +: 8], t_pval[i][p][8*k +: 8]});
			end
		end
		cfg_write(CFG_CTRL_ADDR, t_ctrl[i]);
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic send_frame(input int i);
		logic [7:0] data;
		logic user;
		logic last;
		for (int k = 0; k < t_len[i]; k++) begin
			data = t_frame[i][8*k +: 8];
			user = t_bad[i] && (k == t_len[i] / 2);
			last = (k == t_len[i] - 1);
			@(negedge clk);
			s_tvalid = 1'b1;
			s_tdata = data;
			s_tuser = user;
			s_tlast = last;
			exp_bytes.push_back({data, user, last});
			if (last && (t_exp[i] != '0)) begin
				// Timestamp is the time base seen at the edge that takes the tlast byte
				@(posedge clk);
				if (exp_time_q.size() < EVT_DEPTH) begin
					exp_time_q.push_back(current_time);
					exp_mask_q.push_back(t_exp[i]);
				end else begin
					exp_overflow = 1'b1;
				end
			end
		end
		@(negedge clk);
		s_tvalid = 1'b0;
		s_tuser = 1'b0;
		s_tlast = 1'b0;
	endtask

	// Until every sent byte has left the loop FIFO
	task automatic wait_drain();
		while ((exp_bytes.size() != 0) || m_tvalid) begin
			@(negedge clk);
		end
	endtask

	task automatic pop_events(input int i);
		while (exp_time_q.size() != 0) begin
			check_value({t_name[i], " evt_valid"}, 1, evt_valid);
			check_value({t_name[i], " evt_time"}, exp_time_q.pop_front(), evt_time);
			check_value({t_name[i], " evt_matched"}, exp_mask_q.pop_front(), evt_matched);
			evt_pop = 1'b1;
			@(negedge clk);
			evt_pop = 1'b0;
		end
		check_value({t_name[i], " queue empty"}, 0, evt_valid);
	endtask

	task automatic run_test(input int i);
		int errors_before;
		errors_before = error_count;
		cur_name = t_name[i];
		check_value({t_name[i], " rule"}, rule_mask(i), t_exp[i]);
		load_config(i);
		send_frame(i);
		wait_drain();
		// Event lands two cycles after tlast
		repeat (2) @(negedge clk);
		check_value({t_name[i], " evt_valid"}, exp_time_q.size() != 0, evt_valid);
		check_value({t_name[i], " evt_overflow"}, exp_overflow, evt_overflow);
		if (t_pop[i]) begin
			pop_events(i);
		end
		if (error_count == errors_before) begin
			pass_count++;
			$display("Test %s passed", t_name[i]);
		end else begin
			fail_count++;
			$display("Test %s failed with %0d errors", t_name[i], error_count - errors_before);
		end
	endtask

	// Hang guard sized from the table
	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int total;
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		s_tdata = 8'h00;
		s_tuser = 1'b0;
		s_tlast = 1'b0;
		s_tvalid = 1'b0;
		m_tready = 1'b0;
		evt_pop = 1'b0;
		build_table();
		total = 0;
		for (int i = 0; i < n_tests; i++) begin
			total += t_len[i] + 40;
		end
		watchdog_cycles = total * 4;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end
		$display("Totals: %0d tests, %0d passed, %0d failed, %0d errors",
			n_tests, pass_count, fail_count, error_count);
		if ((error_count == 0) && (fail_count == 0)) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
